// File: flist.f
logic/cachePkg.sv
logic/sram.sv
logic/requestDecode.sv
logic/cacheControl.sv
logic/memPort.sv
logic/dataCache.sv
test/dataCache_asserts.sv
test/dataCache_tb.sv

// File: run.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# The run fails when the log holds the fail message.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module dataCache_tb -f flist.f \
    && ./obj_dir/VdataCache_tb +verilator+error+limit+100000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: test/dataCache_tb.sv
// ========================================
// testbench for the direct mapped data cache
// random loads and stores checked against a
// shadow memory, with a wait state memory
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dataCache_tb;

    localparam int halfPeriod = 50;
    localparam int driveDelay = 10;
    localparam int numRequests = 400;
    localparam int worstMissCycles = 40;
    // idle cycle per request plus reset and the tag sweep
    localparam int cycleLimit = numRequests * (worstMissCycles + 1) + 40;
    localparam int memDepth = 256;
    localparam logic [31:0] lfsrSeed = 32'hc335_0cb1;

    logic                CLK;
    logic                rst;
    logic                cpuRen;
    logic                cpuWen;
    cachePkg::addr_t     cpuAddr;
    cachePkg::word_t     cpuWdata;
    cachePkg::byteEn_t   cpuByteEn;
    logic                cpuDone;
    cachePkg::word_t     cpuRdata;
    logic                memRen;
    logic                memWen;
    cachePkg::addr_t     memAddr;
    cachePkg::word_t     memWdata;
    cachePkg::word_t     memRdata;
    logic                memReady;

    // memory contents and the value each word should read as
    cachePkg::word_t     memWords [memDepth];
    cachePkg::word_t     shadow [memDepth];
    // direct mapped tag mirror
    logic                mirValid [cachePkg::numSets];
    logic                mirDirty [cachePkg::numSets];
    cachePkg::tag_t      mirTag [cachePkg::numSets];

    logic [31:0]         stimLfsr;
    logic [31:0]         memLfsr;
    logic [1:0]          waitLeft;
    int                  dataErrors = 0;
    int                  timeouts = 0;
    int                  donePulses = 0;
    int                  cycleCount = 0;

    dataCache i_dut (
        .CLK(CLK), .rst(rst), .cpuRen(cpuRen), .cpuWen(cpuWen), .cpuAddr(cpuAddr),
        .cpuWdata(cpuWdata), .cpuByteEn(cpuByteEn), .cpuDone(cpuDone), .cpuRdata(cpuRdata),
        .memRen(memRen), .memWen(memWen), .memAddr(memAddr), .memWdata(memWdata),
        .memRdata(memRdata), .memReady(memReady)
    );

    // only the low 10 address bits are ever used
    assign memRdata = memWords[memAddr[9:2]];

    // taps 32 22 2 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic takeBits(input int n, inout logic [31:0] st, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsrNext(st);
            val = {val[30:0], st[0]};
        end
    endtask

    // start value of a word from the whole byte address
    function automatic cachePkg::word_t fillWord(input int slot);
        cachePkg::addr_t a;
        a = cachePkg::addr_t'(slot * 4);
        return (a << 12) ^ (a << 22) ^ a ^ 32'h3C00_0000;
    endfunction

    task automatic closeRun();
        int protoErrors;
        protoErrors = i_dut.protocolChecks.failCount;
        $display("data errors %0d, protocol errors %0d, timeouts %0d",
                 dataErrors, protoErrors, timeouts);
        if (dataErrors + protoErrors + timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // one request held until done and then checked
    task automatic runRequest(input logic write, input cachePkg::addr_t addr,
                              input cachePkg::word_t wdata, input cachePkg::byteEn_t be);
        cachePkg::index_t idx;
        cachePkg::tag_t   tag;
        logic [7:0]       slot;
        logic             predictHit;
        int               cycles;
        idx = addr[7:4];
        tag = addr[31:8];
        slot = addr[9:2];
        predictHit = mirValid[idx] && (mirTag[idx] == tag);
        cpuAddr = addr;
        cpuWdata = wdata;
        cpuByteEn = be;
        cpuWen = write;
        cpuRen = !write;
        // sample edge and then the edges up to done
        @(posedge CLK);
        @(posedge CLK);
        #driveDelay;
        cycles = 1;
        while (!cpuDone) begin
            @(posedge CLK);
            #driveDelay;
            cycles++;
        end
        if (predictHit) begin
            assert (cycles == 2) else begin
                $display("[ERROR] %0t cpuDone latency expected 2 got %0d", $time, cycles);
                dataErrors++;
            end
        end else begin
            assert (cycles > 2) else begin
                $display("Miss at %h answered in %0d cycles as if it hit", addr, cycles);
                dataErrors++;
            end
        end
        if (!write) begin
            assert (cpuRdata == shadow[slot]) else begin
                $display("[ERROR] %0t cpuRdata expected %h got %h",
                         $time, shadow[slot], cpuRdata);
                dataErrors++;
            end
        end else begin
            // only the enabled bytes change
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[slot][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        // a miss brings the line in clean
        if (!predictHit) begin
            mirDirty[idx] = 1'b0;
        end
        if (write) begin
            mirDirty[idx] = 1'b1;
        end
        mirValid[idx] = 1'b1;
        mirTag[idx] = tag;
        // level stays up through the done cycle
        @(posedge CLK);
        #driveDelay;
        cpuRen = 1'b0;
        cpuWen = 1'b0;
        // one edge with both levels low before the next request
        @(posedge CLK);
        #driveDelay;
    endtask

    initial begin
        CLK = 1'b0;
        forever #halfPeriod CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (!rst && cpuDone) begin
            donePulses++;
        end
    end

    // write-back words must carry the merged shadow value
    always @(posedge CLK) begin
        if (!rst && memWen && memReady) begin
            assert (memWdata == shadow[memAddr[9:2]]) else begin
                $display("[ERROR] %0t memWdata at %h expected %h got %h",
                         $time, memAddr, shadow[memAddr[9:2]], memWdata);
                dataErrors++;
            end
            assert (mirValid[memAddr[7:4]] && mirDirty[memAddr[7:4]]
                    && mirTag[memAddr[7:4]] == memAddr[31:8]) else begin
                $display("Write-back at %h is not a dirty line of the mirror", memAddr);
                dataErrors++;
            end
            memWords[memAddr[9:2]] = memWdata;
        end
    end

    // memory model with a ready pulse after 0 to 3 wait states
    initial begin
        memLfsr = lfsrSeed;
        memReady = 1'b0;
        waitLeft = 2'd0;
        for (int i = 0; i < memDepth; i++) begin
            memWords[i] = fillWord(i);
            shadow[i] = fillWord(i);
        end
        forever begin
            @(posedge CLK);
            #driveDelay;
            if (memReady) begin
                logic [31:0] draw;
                memReady = 1'b0;
                takeBits(2, memLfsr, draw);
                waitLeft = draw[1:0];
            end else if (memRen || memWen) begin
                if (waitLeft == 2'd0) begin
                    memReady = 1'b1;
                end else begin
                    waitLeft = waitLeft - 2'd1;
                end
            end
        end
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge CLK);
            cycleCount++;
        end
        #driveDelay;
        $display("Timeout after %0d cycles with requests still running", cycleLimit);
        timeouts = 1;
        closeRun();
    end

    initial begin
        logic [31:0]        draw;
        cachePkg::tag_t     tag;
        logic [1:0]         set;
        logic [1:0]         word;
        logic               write;
        cachePkg::byteEn_t  be;
        cachePkg::word_t    data;
        stimLfsr = lfsrSeed;
        rst = 1'b1;
        cpuRen = 1'b0;
        cpuWen = 1'b0;
        cpuAddr = '0;
        cpuWdata = '0;
        cpuByteEn = '0;
        for (int s = 0; s < cachePkg::numSets; s++) begin
            mirValid[s] = 1'b0;
            mirDirty[s] = 1'b0;
            mirTag[s] = '0;
        end
        repeat (3) @(posedge CLK);
        #driveDelay;
        rst = 1'b0;
        // decode holds requests during the tag sweep
        repeat (cachePkg::numSets + 2) @(posedge CLK);
        #driveDelay;
        // 48 words from three tags on sets 0 5 10 15
        for (int n = 0; n < numRequests; n++) begin
            takeBits(2, stimLfsr, draw);
            tag = cachePkg::tag_t'(draw % 3);
            takeBits(2, stimLfsr, draw);
            set = draw[1:0];
            takeBits(2, stimLfsr, draw);
            word = draw[1:0];
            takeBits(1, stimLfsr, draw);
            write = draw[0];
            takeBits(4, stimLfsr, draw);
            be = draw[3:0];
            takeBits(32, stimLfsr, draw);
            data = draw;
            runRequest(write, {tag, set, set, word, 2'b00}, data, be);
        end
        @(posedge CLK);
        #driveDelay;
        assert (donePulses == numRequests) else begin
            $display("[ERROR] %0t cpuDone pulses expected %0d got %0d",
                     $time, numRequests, donePulses);
            dataErrors++;
        end
        closeRun();
    end

endmodule

`default_nettype wire

// File: test/dataCache_asserts.sv
// ========================================
// protocol checks bound into the cache top
// done pulse, memory levels and addresses
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dataCache_asserts (
    input logic                  CLK,
    input logic                  rst,
    input logic                  cpuRen,
    input logic                  cpuWen,
    input logic                  cpuDone,
    input logic                  memRen,
    input logic                  memWen,
    input cachePkg::addr_t       memAddr,
    input logic                  memReady,
    input cachePkg::ctrlState_t  ctrlState
);

    // failed checks so far
    int   failCount = 0;
    logic seenReq;

    always_ff @(posedge CLK) begin
        if (rst) begin
            seenReq <= 1'b0;
        end else if (cpuRen || cpuWen) begin
            seenReq <= 1'b1;
        end
    end

    // quiet until the first request
    quietUntilRequest: assert property (@(posedge CLK) disable iff (rst)
        !seenReq |-> !cpuDone && !memRen && !memWen)
    else begin
        $error("cache became active before any request");
        failCount = failCount + 1;
    end

    oneMemLevel: assert property (@(posedge CLK) disable iff (rst) !(memRen && memWen))
    else begin
        $error("memRen and memWen high together");
        failCount = failCount + 1;
    end

    // address only moves on a ready pulse
    addrHeld: assert property (@(posedge CLK) disable iff (rst)
        (memRen || memWen) && !memReady |=> $stable(memAddr))
    else begin
        $error("memAddr changed without a ready pulse");
        failCount = failCount + 1;
    end

    addrSteps: assert property (@(posedge CLK) disable iff (rst)
        (memRen || memWen) && memReady && memAddr[3:2] != 2'b11
        |=> memAddr == $past(memAddr) + 32'd4)
    else begin
        $error("memAddr did not step to the next word");
        failCount = failCount + 1;
    end

    lineBaseStart: assert property (@(posedge CLK) disable iff (rst)
        $rose(memRen || memWen) |-> memAddr[3:0] == 4'h0)
    else begin
        $error("line transfer did not start at the line base");
        failCount = failCount + 1;
    end

    donePulse: assert property (@(posedge CLK) disable iff (rst)
        cpuDone |=> !cpuDone)
    else begin
        $error("cpuDone stayed high for more than one cycle");
        failCount = failCount + 1;
    end

    doneWithRequest: assert property (@(posedge CLK) disable iff (rst)
        cpuDone |-> cpuRen || cpuWen)
    else begin
        $error("cpuDone without a request level");
        failCount = failCount + 1;
    end

    // write level only in writeBack, read level only in refill
    levelMatchesState: assert property (@(posedge CLK) disable iff (rst)
        (!memWen || ctrlState == cachePkg::writeBack)
        && (!memRen || ctrlState == cachePkg::refill))
    else begin
        $error("memory level outside its controller state");
        failCount = failCount + 1;
    end

endmodule

bind dataCache dataCache_asserts protocolChecks (
    .CLK(CLK), .rst(rst), .cpuRen(cpuRen), .cpuWen(cpuWen), .cpuDone(cpuDone),
    .memRen(memRen), .memWen(memWen), .memAddr(memAddr), .memReady(memReady),
    .ctrlState(controlUnit.state)
);

`default_nettype wire

// File: logic/dataCache.sv
// ========================================
// blocking direct mapped data cache top
// decode, controller, tag and data arrays
// and the memory port, wired together
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dataCache (
    input  logic               CLK,
    input  logic               rst,
    input  logic               cpuRen,
    input  logic               cpuWen,
    input  cachePkg::addr_t    cpuAddr,
    input  cachePkg::word_t    cpuWdata,
    input  cachePkg::byteEn_t  cpuByteEn,
    output logic               cpuDone,
    output cachePkg::word_t    cpuRdata,
    output logic               memRen,
    output logic               memWen,
    output cachePkg::addr_t    memAddr,
    output cachePkg::word_t    memWdata,
    input  cachePkg::word_t    memRdata,
    input  logic               memReady
);

    logic                 reqValid;
    logic                 reqWrite;
    cachePkg::tag_t       reqTag;
    cachePkg::index_t     reqIndex;
    cachePkg::offset_t    reqWord;
    cachePkg::line_t      reqLineData;
    cachePkg::line_t      reqKeepMask;
    logic                 tagRen;
    logic                 tagWen;
    logic                 dataRen;
    logic                 dataWen;
    cachePkg::index_t     arraySel;
    cachePkg::tagEntry_t  tagWval;
    cachePkg::tagEntry_t  tagRval;
    cachePkg::line_t      dataWval;
    cachePkg::line_t      dataWmask;
    cachePkg::line_t      dataRval;
    logic                 startWriteBack;
    logic                 startRefill;
    cachePkg::addr_t      lineBase;
    cachePkg::line_t      lineOut;
    cachePkg::line_t      lineIn;
    logic                 xferDone;

    requestDecode decodeUnit (
        .CLK(CLK), .rst(rst), .cpuRen(cpuRen), .cpuWen(cpuWen), .cpuAddr(cpuAddr),
        .cpuWdata(cpuWdata), .cpuByteEn(cpuByteEn), .cpuDone(cpuDone),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqTag(reqTag), .reqIndex(reqIndex),
        .reqWord(reqWord), .reqLineData(reqLineData), .reqKeepMask(reqKeepMask)
    );

    cacheControl controlUnit (
        .CLK(CLK), .rst(rst), .reqValid(reqValid), .reqWrite(reqWrite), .reqTag(reqTag),
        .reqIndex(reqIndex), .reqWord(reqWord), .reqLineData(reqLineData),
        .reqKeepMask(reqKeepMask), .tagRval(tagRval), .dataRval(dataRval),
        .tagRen(tagRen), .tagWen(tagWen), .dataRen(dataRen), .dataWen(dataWen),
        .arraySel(arraySel), .tagWval(tagWval), .dataWval(dataWval), .dataWmask(dataWmask),
        .cpuDone(cpuDone), .cpuRdata(cpuRdata), .startWriteBack(startWriteBack),
        .startRefill(startRefill), .lineBase(lineBase), .lineOut(lineOut),
        .lineIn(lineIn), .xferDone(xferDone)
    );

    // tag entries are always written whole
    sram #(.wrSize(cachePkg::tagEntryBits), .height(cachePkg::numSets)) tagArray (
        .CLK(CLK), .wVal(tagWval), .rVal(tagRval), .REN(tagRen), .WEN(tagWen),
        .SEL(arraySel), .wMask('0)
    );

    sram #(.wrSize(cachePkg::lineBits), .height(cachePkg::numSets)) dataArray (
        .CLK(CLK), .wVal(dataWval), .rVal(dataRval), .REN(dataRen), .WEN(dataWen),
        .SEL(arraySel), .wMask(dataWmask)
    );

    memPort memoryPort (
        .CLK(CLK), .rst(rst), .startWriteBack(startWriteBack), .startRefill(startRefill),
        .lineBase(lineBase), .lineOut(lineOut), .lineIn(lineIn), .xferDone(xferDone),
        .memRen(memRen), .memWen(memWen), .memAddr(memAddr), .memWdata(memWdata),
        .memRdata(memRdata), .memReady(memReady)
    );

endmodule

`default_nettype wire

// File: logic/memPort.sv
// ========================================
// word serial memory port
// moves one line to or from memory as four
// word transfers, one per ready pulse
// ========================================

`timescale 1ns/1ps
`default_nettype none

module memPort (
    input  logic             CLK,
    input  logic             rst,
    input  logic             startWriteBack,
    input  logic             startRefill,
    input  cachePkg::addr_t  lineBase,
    input  cachePkg::line_t  lineOut,
    output cachePkg::line_t  lineIn,
    output logic             xferDone,
    output logic             memRen,
    output logic             memWen,
    output cachePkg::addr_t  memAddr,
    output cachePkg::word_t  memWdata,
    input  cachePkg::word_t  memRdata,
    input  logic             memReady
);

    logic               busy;
    logic               isWrite;
    logic               done;
    cachePkg::offset_t  wordCnt;
    cachePkg::addr_t    addrReg;
    cachePkg::line_t    lineBuf;

    // levels held for all four words
    assign memRen   = busy & ~isWrite;
    assign memWen   = busy & isWrite;
    assign memAddr  = addrReg;
    assign memWdata = lineBuf[wordCnt * cachePkg::wordBits +: cachePkg::wordBits];
    assign lineIn   = lineBuf;
    assign xferDone = done;

    always_ff @(posedge CLK) begin
        if (rst) begin
            busy    <= 1'b0;
            isWrite <= 1'b0;
            done    <= 1'b0;
            wordCnt <= '0;
        end else begin
            done <= 1'b0;
            if (!busy && (startWriteBack || startRefill)) begin
                busy    <= 1'b1;
                isWrite <= startWriteBack;
                wordCnt <= '0;
            end else if (busy && memReady) begin
                wordCnt <= wordCnt + 1'b1;
                // last word, done pulses one cycle later
                if (wordCnt == cachePkg::offset_t'(cachePkg::wordsPerLine - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // address and line buffer
    always_ff @(posedge CLK) begin
        if (!busy && (startWriteBack || startRefill)) begin
            addrReg <= lineBase;
            lineBuf <= lineOut;
        end else if (busy && memReady) begin
            // step to the next word
            addrReg <= addrReg + cachePkg::addr_t'(cachePkg::wordBits / 8);
            if (!isWrite) begin
                lineBuf[wordCnt * cachePkg::wordBits +: cachePkg::wordBits] <= memRdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cacheControl.sv
// ========================================
// cache controller FSM
// tag compare, hit handling, write-back of
// dirty victims and line refill
// also runs the tag invalidate sweep
// ========================================

`timescale 1ns/1ps
`default_nettype none

module cacheControl (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  reqValid,
    input  logic                  reqWrite,
    input  cachePkg::tag_t        reqTag,
    input  cachePkg::index_t      reqIndex,
    input  cachePkg::offset_t     reqWord,
    input  cachePkg::line_t       reqLineData,
    input  cachePkg::line_t       reqKeepMask,
    input  cachePkg::tagEntry_t   tagRval,
    input  cachePkg::line_t       dataRval,
    output logic                  tagRen,
    output logic                  tagWen,
    output logic                  dataRen,
    output logic                  dataWen,
    output cachePkg::index_t      arraySel,
    output cachePkg::tagEntry_t   tagWval,
    output cachePkg::line_t       dataWval,
    output cachePkg::line_t       dataWmask,
    output logic                  cpuDone,
    output cachePkg::word_t       cpuRdata,
    output logic                  startWriteBack,
    output logic                  startRefill,
    output cachePkg::addr_t       lineBase,
    output cachePkg::line_t       lineOut,
    input  cachePkg::line_t       lineIn,
    input  logic                  xferDone
);

    cachePkg::ctrlState_t state;
    cachePkg::ctrlState_t nextState;

    logic                 sweeping;
    cachePkg::index_t     sweepCnt;

    logic                 storedValid;
    logic                 storedDirty;
    cachePkg::tag_t       storedTag;
    logic                 hit;
    logic                 victimDirty;
    cachePkg::addr_t      reqBase;
    cachePkg::addr_t      victimBase;

    // fields of the stored entry for this set
    assign storedValid = tagRval[cachePkg::validPos];
    assign storedDirty = tagRval[cachePkg::dirtyPos];
    assign storedTag   = tagRval[cachePkg::tagBits-1:0];

    assign hit         = storedValid & (storedTag == reqTag);
    assign victimDirty = storedValid & storedDirty;

    // line aligned base addresses
    assign reqBase    = {reqTag, reqIndex,
                         {(cachePkg::offsetBits + cachePkg::byteOffBits){1'b0}}};
    assign victimBase = {storedTag, reqIndex,
                         {(cachePkg::offsetBits + cachePkg::byteOffBits){1'b0}}};

    // victim line straight from the data array
    assign lineOut = dataRval;

    assign cpuDone = (state == cachePkg::respond);

    always_comb begin
        nextState      = state;
        tagRen         = 1'b0;
        tagWen         = 1'b0;
        dataRen        = 1'b0;
        dataWen        = 1'b0;
        arraySel       = reqIndex;
        tagWval        = '0;
        dataWval       = reqLineData;
        dataWmask      = reqKeepMask;
        startWriteBack = 1'b0;
        startRefill    = 1'b0;
        lineBase       = reqBase;
        case (state)
            cachePkg::idle: begin
                // invalidate one set per cycle after reset
                if (sweeping) begin
                    tagWen   = 1'b1;
                    arraySel = sweepCnt;
                end else if (reqValid) begin
                    nextState = cachePkg::compare;
                end
            end
            cachePkg::compare: begin
                tagRen  = 1'b1;
                dataRen = 1'b1;
                if (hit) begin
                    nextState = cachePkg::respond;
                    // write hit merges and marks the line dirty
                    if (reqWrite) begin
                        dataWen = 1'b1;
                        tagWen  = 1'b1;
                        tagWval = {1'b1, 1'b1, reqTag};
                    end
                end else if (victimDirty) begin
                    startWriteBack = 1'b1;
                    lineBase       = victimBase;
                    nextState      = cachePkg::writeBack;
                end else begin
                    startRefill = 1'b1;
                    nextState   = cachePkg::refill;
                end
            end
            cachePkg::writeBack: begin
                // victim is out, fetch the new line
                if (xferDone) begin
                    startRefill = 1'b1;
                    nextState   = cachePkg::refill;
                end
            end
            cachePkg::refill: begin
                // whole line, clean tag, then compare again
                if (xferDone) begin
                    tagWen    = 1'b1;
                    tagWval   = {1'b1, 1'b0, reqTag};
                    dataWen   = 1'b1;
                    dataWval  = lineIn;
                    dataWmask = '0;
                    nextState = cachePkg::compare;
                end
            end
            cachePkg::respond: begin
                nextState = cachePkg::idle;
            end
            default: begin
                nextState = cachePkg::idle;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state    <= cachePkg::idle;
            sweeping <= 1'b1;
            sweepCnt <= '0;
        end else begin
            state <= nextState;
            if (sweeping) begin
                sweepCnt <= sweepCnt + 1'b1;
                if (sweepCnt == cachePkg::index_t'(cachePkg::numSets - 1)) begin
                    sweeping <= 1'b0;
                end
            end
        end
    end

    // read word captured on the read hit
    always_ff @(posedge CLK) begin
        if (state == cachePkg::compare && hit && !reqWrite) begin
            cpuRdata <= dataRval[reqWord * cachePkg::wordBits +: cachePkg::wordBits];
        end
    end

endmodule

`default_nettype wire

// File: logic/requestDecode.sv
// ========================================
// processor request capture
// takes each held request once, splits the
// address and builds line wide write data
// ========================================

`timescale 1ns/1ps
`default_nettype none

module requestDecode (
    input  logic               CLK,
    input  logic               rst,
    input  logic               cpuRen,
    input  logic               cpuWen,
    input  cachePkg::addr_t    cpuAddr,
    input  cachePkg::word_t    cpuWdata,
    input  cachePkg::byteEn_t  cpuByteEn,
    input  logic               cpuDone,
    output logic               reqValid,
    output logic               reqWrite,
    output cachePkg::tag_t     reqTag,
    output cachePkg::index_t   reqIndex,
    output cachePkg::offset_t  reqWord,
    output cachePkg::line_t    reqLineData,
    output cachePkg::line_t    reqKeepMask
);

    logic               pending;
    logic               warming;
    cachePkg::index_t   warmCnt;
    cachePkg::offset_t  wordSel;
    cachePkg::line_t    keepMask;
    logic               sample;

    assign wordSel = cpuAddr[cachePkg::byteOffBits +: cachePkg::offsetBits];

    // a held level is only taken while nothing is pending
    assign sample = (cpuRen | cpuWen) & ~pending;

    // clear only the enabled bytes of the addressed word
    always_comb begin
        keepMask = '1;
        if (cpuWen) begin
            for (int b = 0; b < cachePkg::wordBits / 8; b++) begin
                if (cpuByteEn[b]) begin
                    keepMask[wordSel * cachePkg::wordBits + b * 8 +: 8] = 8'h00;
                end
            end
        end
    end

    // pending stays up through the 16 cycle tag sweep after reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            pending  <= 1'b1;
            warming  <= 1'b1;
            warmCnt  <= '0;
            reqValid <= 1'b0;
        end else begin
            reqValid <= sample;
            if (warming) begin
                warmCnt <= warmCnt + 1'b1;
                if (warmCnt == cachePkg::index_t'(cachePkg::numSets - 1)) begin
                    warming <= 1'b0;
                    pending <= 1'b0;
                end
            end else if (cpuDone) begin
                pending <= 1'b0;
            end else if (sample) begin
                pending <= 1'b1;
            end
        end
    end

    // request fields, held until the next sample
    always_ff @(posedge CLK) begin
        if (sample) begin
            reqWrite    <= cpuWen;
            reqTag      <= cpuAddr[cachePkg::addrBits-1 -: cachePkg::tagBits];
            reqIndex    <= cpuAddr[cachePkg::byteOffBits + cachePkg::offsetBits +: cachePkg::indexBits];
            reqWord     <= wordSel;
            // same word in every lane, the mask picks the lane
            reqLineData <= {cachePkg::wordsPerLine{cpuWdata}};
            reqKeepMask <= keepMask;
        end
    end

endmodule

`default_nettype wire

// File: logic/sram.sv
// ========================================
// single port storage array
// registered rows with masked writes
// read is combinational while REN is high
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sram #(
    parameter int wrSize = 128,
    parameter int height = 16
) (
    input  logic                      CLK,
    input  logic [wrSize-1:0]         wVal,
    output logic [wrSize-1:0]         rVal,
    input  logic                      REN,
    input  logic                      WEN,
    input  logic [$clog2(height)-1:0] SEL,
    input  logic [wrSize-1:0]         wMask
);

    logic [wrSize-1:0] mem [height];

    // mask bit one keeps the stored bit, zero takes the new one
    always_ff @(posedge CLK) begin
        if (WEN) begin
            mem[SEL] <= (wVal & ~wMask) | (wMask & mem[SEL]);
        end
    end

    // poison pattern when the array is not being read
    always_comb begin
        for (int i = 0; i < wrSize; i++) begin
            rVal[i] = cachePkg::poisonWord[i % 32];
        end
        if (REN) begin
            rVal = mem[SEL];
        end
    end

endmodule

`default_nettype wire

// File: logic/cachePkg.sv
// ========================================
// shared geometry, widths and FSM states
// for the direct mapped data cache
// every block refers to these by scoped name
// ========================================

`default_nettype none

package cachePkg;

    // byte address and data word
    localparam int addrBits = 32;
    localparam int wordBits = 32;

    // line geometry, four words per line
    localparam int wordsPerLine = 4;
    localparam int lineBits = wordsPerLine * wordBits;

    // 16 sets, direct mapped
    localparam int numSets = 16;
    localparam int indexBits = 4;
    localparam int offsetBits = 2;
    localparam int byteOffBits = 2;
    localparam int tagBits = addrBits - indexBits - offsetBits - byteOffBits;

    // tag entry is valid, dirty, then the tag itself
    localparam int tagEntryBits = tagBits + 2;
    localparam int validPos = tagEntryBits - 1;
    localparam int dirtyPos = tagEntryBits - 2;

    // read value of an SRAM that is not enabled
    localparam logic [31:0] poisonWord = 32'hBAD0_BAD0;

    typedef logic [addrBits-1:0] addr_t;
    typedef logic [wordBits-1:0] word_t;
    typedef logic [lineBits-1:0] line_t;
    typedef logic [tagBits-1:0] tag_t;
    typedef logic [indexBits-1:0] index_t;
    typedef logic [offsetBits-1:0] offset_t;
    typedef logic [tagEntryBits-1:0] tagEntry_t;
    typedef logic [wordBits/8-1:0] byteEn_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        compare,
        writeBack,
        refill,
        respond
    } ctrlState_t;

endpackage

`default_nettype wire
